/* source/a8_pkg.sv */
// ============================================================
// Shared widths, types and constants of the ROM and mouse glue
// Index decode follows the host menu file numbering
// ============================================================

package a8_pkg;

	// ============================================================
	// Widths
	// ============================================================
	localparam int BYTE_W     = 8;
	localparam int ROM_ADDR_W = 15;
	localparam int OS_ADDR_W  = 14;
	localparam int BAS_ADDR_W = 13;
	localparam int AXIS_W     = 8;
	localparam int JOY_BTN_W  = 14;

	typedef logic [BYTE_W-1:0]        byte_t;
	typedef logic [ROM_ADDR_W-1:0]    rom_addr_t;
	typedef logic [OS_ADDR_W-1:0]     os_addr_t;
	typedef logic [BAS_ADDR_W-1:0]    bas_addr_t;
	typedef logic signed [AXIS_W-1:0] axis_t;
	// One guard bit for the sum before clamping
	typedef logic signed [AXIS_W:0]   axis_sum_t;
	typedef logic [JOY_BTN_W-1:0]     joy_btn_t;
	typedef logic [7:0]               file_idx_t;

	// ============================================================
	// Constants
	// ============================================================
	localparam file_idx_t IDX_OS_BOOT  = 8'h00;
	localparam file_idx_t IDX_OS_MENU  = 8'h04;
	localparam file_idx_t IDX_BAS_BOOT = 8'h40;
	localparam file_idx_t IDX_BAS_MENU = 8'h05;

	localparam byte_t FILL_BYTE = 8'hFF;

	localparam int MOUSE_STEP_MAX     = 10;
	localparam int AXIS_MIN           = -128;
	localparam int AXIS_MAX           = 127;
	localparam int RESET_PULSE_CYCLES = 1000;

	typedef logic [$clog2(RESET_PULSE_CYCLES)-1:0] rst_cnt_t;

	// Host download stream, one byte per wr strobe
	typedef struct packed {
		logic      wr;
		logic      download;
		file_idx_t index;
		os_addr_t  addr;
		byte_t     dout;
	} host_load_t;

	// PS/2 mouse word as delivered by the host, low bits of each delta unused
	typedef struct packed {
		logic       strobe;
		logic [6:0] dy;
		logic       dy_lsb;
		logic [6:0] dx;
		logic       dx_lsb;
		logic [1:0] ovf;
		logic       y_sign;
		logic       x_sign;
		logic [1:0] rsvd;
		logic [1:0] btn;
	} ps2_mouse_t;

	// MENU forms match on the low six index bits only
	function automatic logic is_os_index(input file_idx_t idx);
		return (idx == IDX_OS_BOOT) || (idx[5:0] == IDX_OS_MENU[5:0]);
	endfunction

	function automatic logic is_bas_index(input file_idx_t idx);
		return (idx == IDX_BAS_BOOT) || (idx[5:0] == IDX_BAS_MENU[5:0]);
	endfunction

endpackage

/* source/rom_bank.sv */
// ============================================================
// Download-filled ROM bank, short images sit at the top of the space
// Read data and FF padding arrive one cycle after the address
// ============================================================

`timescale 1ns/1ps

module rom_bank #(
	parameter int ADDR_W = 14
) (
	input  logic              clk_sys,
	input  logic              areset,

	input  logic              wr_i,
	input  logic [ADDR_W-1:0] wr_addr_i,
	input  a8_pkg::byte_t     wr_data_i,

	input  logic [ADDR_W-1:0] rd_addr_i,
	output a8_pkg::byte_t     rd_data_o
);
	import a8_pkg::*;

	typedef logic [ADDR_W-1:0] addr_t;

	byte_t mem [2**ADDR_W];
	addr_t offset_q;
	addr_t rd_index;
	byte_t mem_q;
	logic  fill_q;

	// Image start moves down as the download grows
	assign rd_index = rd_addr_i - offset_q;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			offset_q <= '0;
		end else if (wr_i) begin
			offset_q <= {ADDR_W{1'b1}} - wr_addr_i;
		end
	end

	// ============================================================
	// Storage and read port
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (wr_i) begin
			mem[wr_addr_i] <= wr_data_i;
		end
		mem_q <= mem[rd_index];
	end

	// Below the image start nothing was loaded
	always_ff @(posedge clk_sys) begin
		fill_q <= (rd_addr_i < offset_q);
	end

	assign rd_data_o = fill_q ? FILL_BYTE : mem_q;

endmodule

/* source/rom_loader.sv */
// ============================================================
// OS and BASIC banks with the CPU-side read mux
// BASIC enable is taken while reset is held and kept after it
// ============================================================

`timescale 1ns/1ps

module rom_loader (
	input  logic               clk_sys,
	input  logic               areset,

	input  a8_pkg::host_load_t load_i,
	input  logic               basic_en_i,

	input  a8_pkg::rom_addr_t  rom_addr_i,
	output a8_pkg::byte_t      rom_data_o,

	output logic               basic_en_o
);
	import a8_pkg::*;

	logic      os_wr;
	logic      bas_wr;
	logic      basic_en_q;
	rom_addr_t addr_q;
	byte_t     os_data;
	byte_t     bas_data;

	// ============================================================
	// Write decode
	// ============================================================
	// Index sets are disjoint, so at most one bank is written
	assign os_wr  = load_i.wr & is_os_index(load_i.index);
	assign bas_wr = load_i.wr & is_bas_index(load_i.index);

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			basic_en_q <= basic_en_i;
		end
	end

	assign basic_en_o = basic_en_q;

	rom_bank #(
		.ADDR_W(OS_ADDR_W)
	) os_bank_i (
		.clk_sys  (clk_sys),
		.areset   (areset),
		.wr_i     (os_wr),
		.wr_addr_i(load_i.addr),
		.wr_data_i(load_i.dout),
		.rd_addr_i(rom_addr_i[OS_ADDR_W-1:0]),
		.rd_data_o(os_data)
	);

	rom_bank #(
		.ADDR_W(BAS_ADDR_W)
	) bas_bank_i (
		.clk_sys  (clk_sys),
		.areset   (areset),
		.wr_i     (bas_wr),
		.wr_addr_i(load_i.addr[BAS_ADDR_W-1:0]),
		.wr_data_i(load_i.dout),
		.rd_addr_i(rom_addr_i[BAS_ADDR_W-1:0]),
		.rd_data_o(bas_data)
	);

	// ============================================================
	// Read mux
	// ============================================================
	// Address delayed to line up with the bank read latency
	always_ff @(posedge clk_sys) begin
		addr_q <= rom_addr_i;
	end

	always_comb begin
		if (addr_q[ROM_ADDR_W-1]) begin
			rom_data_o = os_data;
		end else if (addr_q[ROM_ADDR_W-1 -: 2] == 2'b00 && basic_en_q) begin
			rom_data_o = bas_data;
		end else begin
			// Upper half of the low 16K and disabled BASIC
			rom_data_o = FILL_BYTE;
		end
	end

endmodule

/* source/load_reset_gen.sv */
// ============================================================
// Cold reset request after a download of an active system ROM
// Pulse starts two cycles after download falls
// ============================================================

`timescale 1ns/1ps

module load_reset_gen (
	input  logic               clk_sys,
	input  logic               areset,
	input  a8_pkg::host_load_t load_i,
	input  logic               basic_en_i,
	output logic               cold_reset_o
);
	import a8_pkg::*;

	logic     hit;
	logic     required_q;
	logic     sys_dl_q;
	logic     start_q;
	rst_cnt_t cnt_q;

	// A byte counts if it lands in a bank the machine runs from
	assign hit = load_i.wr & (is_os_index(load_i.index) |
		(is_bas_index(load_i.index) & basic_en_i));

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			sys_dl_q   <= 1'b0;
			start_q    <= 1'b0;
			required_q <= 1'b0;
			cnt_q      <= '0;
			cold_reset_o <= 1'b0;
		end else begin
			sys_dl_q <= load_i.download &
				(is_os_index(load_i.index) | is_bas_index(load_i.index));
			// Registered end of transfer
			start_q <= sys_dl_q & ~load_i.download;

			if (start_q) begin
				required_q <= 1'b0;
			end else if (load_i.download && hit) begin
				required_q <= 1'b1;
			end

			if (start_q) begin
				cold_reset_o <= required_q;
				cnt_q        <= rst_cnt_t'(RESET_PULSE_CYCLES - 1);
			end else if (cnt_q != '0) begin
				cnt_q <= cnt_q - 1'b1;
			end else begin
				cold_reset_o <= 1'b0;
			end
		end
	end

endmodule

/* source/mouse_axis.sv */
// ============================================================
// Mouse packets drive analog stick one and fire buttons 8:7
// Any real stick movement or a CPU halt hands control back
// ============================================================

`timescale 1ns/1ps

module mouse_axis (
	input  logic               clk_sys,
	input  logic               areset,

	input  a8_pkg::ps2_mouse_t mouse_i,
	input  logic               invert_y_i,

	input  a8_pkg::axis_t      joy_analog_x_i,
	input  a8_pkg::axis_t      joy_analog_y_i,
	input  a8_pkg::joy_btn_t   joy_buttons_i,
	input  logic               cpu_halt_i,

	output a8_pkg::axis_t      axis_x_o,
	output a8_pkg::axis_t      axis_y_o,
	output a8_pkg::joy_btn_t   joy_buttons_o
);
	import a8_pkg::*;

	logic      strobe_q;
	logic      packet;
	logic      release_req;
	logic      ctrl_q;
	axis_t     acc_x_q;
	axis_t     acc_y_q;
	axis_sum_t dx_step;
	axis_sum_t dy_step;
	axis_sum_t sum_x;
	axis_sum_t sum_y;

	// Per-packet delta limited to the step range
	function automatic axis_sum_t clamp_step(input axis_sum_t d);
		if (d > axis_sum_t'(MOUSE_STEP_MAX)) begin
			return axis_sum_t'(MOUSE_STEP_MAX);
		end
		if (d < axis_sum_t'(-MOUSE_STEP_MAX)) begin
			return axis_sum_t'(-MOUSE_STEP_MAX);
		end
		return d;
	endfunction

	function automatic axis_t clamp_axis(input axis_sum_t s);
		if (s > axis_sum_t'(AXIS_MAX)) begin
			return axis_t'(AXIS_MAX);
		end
		if (s < axis_sum_t'(AXIS_MIN)) begin
			return axis_t'(AXIS_MIN);
		end
		return s[AXIS_W-1:0];
	endfunction

	// ============================================================
	// Accumulation
	// ============================================================
	assign packet      = (mouse_i.strobe != strobe_q);
	assign release_req = (joy_analog_x_i != '0) || (joy_analog_y_i != '0) || cpu_halt_i;

	assign dx_step = clamp_step({mouse_i.x_sign, mouse_i.x_sign, mouse_i.dx});
	assign dy_step = clamp_step({mouse_i.y_sign, mouse_i.y_sign, mouse_i.dy});

	assign sum_x = axis_sum_t'(acc_x_q) + dx_step;
	assign sum_y = invert_y_i ? (axis_sum_t'(acc_y_q) - dy_step) :
		(axis_sum_t'(acc_y_q) + dy_step);

	// Strobe history only, so no clear is needed
	always_ff @(posedge clk_sys) begin
		strobe_q <= mouse_i.strobe;
	end

	always_ff @(posedge clk_sys) begin
		if (areset || release_req) begin
			ctrl_q  <= 1'b0;
			acc_x_q <= '0;
			acc_y_q <= '0;
		end else if (packet) begin
			ctrl_q  <= 1'b1;
			acc_x_q <= clamp_axis(sum_x);
			acc_y_q <= clamp_axis(sum_y);
		end
	end

	// ============================================================
	// Output select
	// ============================================================
	assign axis_x_o = ctrl_q ? acc_x_q : joy_analog_x_i;
	assign axis_y_o = ctrl_q ? acc_y_q : joy_analog_y_i;

	assign joy_buttons_o = {joy_buttons_i[13:9],
		ctrl_q ? mouse_i.btn : joy_buttons_i[8:7],
		joy_buttons_i[6:0]};

endmodule

/* source/a8_host_top.sv */
// ============================================================
// Host glue around the system ROMs and the mouse stick input
// Download stream has no back-pressure, every strobe is taken
// ============================================================

`timescale 1ns/1ps

module a8_host_top (
	input  logic               clk_sys,
	input  logic               areset,

	// Host download and machine config
	input  a8_pkg::host_load_t load_i,
	input  logic               basic_en_i,

	// CPU ROM port
	input  a8_pkg::rom_addr_t  rom_addr_i,
	output a8_pkg::byte_t      rom_data_o,

	output logic               cold_reset_o,

	// Pointer and stick inputs
	input  a8_pkg::ps2_mouse_t mouse_i,
	input  logic               invert_y_i,
	input  a8_pkg::axis_t      joy_analog_x_i,
	input  a8_pkg::axis_t      joy_analog_y_i,
	input  a8_pkg::joy_btn_t   joy_buttons_i,
	input  logic               cpu_halt_i,

	output a8_pkg::axis_t      axis_x_o,
	output a8_pkg::axis_t      axis_y_o,
	output a8_pkg::joy_btn_t   joy_buttons_o
);

	// Latched BASIC enable shared by the loader and the reset logic
	logic basic_en;

	rom_loader rom_loader_i (
		.clk_sys   (clk_sys),
		.areset    (areset),
		.load_i    (load_i),
		.basic_en_i(basic_en_i),
		.rom_addr_i(rom_addr_i),
		.rom_data_o(rom_data_o),
		.basic_en_o(basic_en)
	);

	load_reset_gen load_reset_gen_i (
		.clk_sys     (clk_sys),
		.areset      (areset),
		.load_i      (load_i),
		.basic_en_i  (basic_en),
		.cold_reset_o(cold_reset_o)
	);

	mouse_axis mouse_axis_i (
		.clk_sys       (clk_sys),
		.areset        (areset),
		.mouse_i       (mouse_i),
		.invert_y_i    (invert_y_i),
		.joy_analog_x_i(joy_analog_x_i),
		.joy_analog_y_i(joy_analog_y_i),
		.joy_buttons_i (joy_buttons_i),
		.cpu_halt_i    (cpu_halt_i),
		.axis_x_o      (axis_x_o),
		.axis_y_o      (axis_y_o),
		.joy_buttons_o (joy_buttons_o)
	);

endmodule

/* tests/clk_gen.sv */
// ============================================================
// Testbench clock of 4 ns and a power-on reset of two cycles
// ============================================================

`timescale 1ns/1ps

module clk_gen (
	output logic clk_sys_o,
	output logic areset_o
);

	initial begin
		clk_sys_o = 1'b0;
		areset_o  = 1'b1;
		// Held across the first two rising edges
		repeat (2) @(negedge clk_sys_o);
		areset_o = 1'b0;
	end

	always #2 clk_sys_o = ~clk_sys_o;

endmodule

/* tests/tb_top.sv */
// ============================================================
// Random ROM download, cold reset and mouse tests with a model
// Inputs change on the falling edge, outputs sampled there too
// ============================================================

`timescale 1ns/1ps

module tb_top;
	import a8_pkg::*;

	localparam int N_READS     = 600;
	localparam int N_MOUSE     = 400;
	localparam int N_DRIFT     = 100;
	localparam int TEST_CYCLES = 16384 + 8192 + 600 + 5 * N_READS + 2 * 1100 +
		(N_MOUSE + 2 * N_DRIFT) * 2 + 200;

	logic clk_sys, rst_gen, reset_req, areset;
	host_load_t load;
	logic basic_en_i, invert_y_i, cpu_halt_i, cold_reset_o;
	rom_addr_t rom_addr_i;
	byte_t rom_data_o;
	ps2_mouse_t mouse_i;
	axis_t joy_x, joy_y, axis_x_o, axis_y_o;
	joy_btn_t joy_buttons_i, joy_buttons_o;

	// Reference model state
	byte_t os_mem [2**OS_ADDR_W];
	byte_t bas_mem [2**BAS_ADDR_W];
	os_addr_t os_off;
	bas_addr_t bas_off;
	logic bas_en_m, ctrl_m, strobe_m;
	int acc_x, acc_y, pulse_left;
	integer seed;

	assign areset = rst_gen | reset_req;

	clk_gen clk_gen_i (.clk_sys_o(clk_sys), .areset_o(rst_gen));

	a8_host_top dut_i (
		.clk_sys(clk_sys), .areset(areset), .load_i(load), .basic_en_i(basic_en_i),
		.rom_addr_i(rom_addr_i), .rom_data_o(rom_data_o), .cold_reset_o(cold_reset_o),
		.mouse_i(mouse_i), .invert_y_i(invert_y_i), .joy_analog_x_i(joy_x),
		.joy_analog_y_i(joy_y), .joy_buttons_i(joy_buttons_i), .cpu_halt_i(cpu_halt_i),
		.axis_x_o(axis_x_o), .axis_y_o(axis_y_o), .joy_buttons_o(joy_buttons_o)
	);

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	function automatic int clamp_int(input int v, input int lo, input int hi);
		if (v > hi) return hi;
		if (v < lo) return lo;
		return v;
	endfunction

	// Delta word is two's complement with the sign bit on top
	function automatic int mouse_delta(input logic sign, input logic [6:0] mag);
		int d;
		d = sign ? int'(mag) - 128 : int'(mag);
		return clamp_int(d, -MOUSE_STEP_MAX, MOUSE_STEP_MAX);
	endfunction

	function automatic byte_t expected_rom(input rom_addr_t a);
		os_addr_t oa;
		bas_addr_t ba;
		oa = a[13:0];
		ba = a[12:0];
		if (a[14]) return (oa < os_off) ? 8'hFF : os_mem[oa - os_off];
		if (a[14:13] == 2'b00 && bas_en_m) return (ba < bas_off) ? 8'hFF : bas_mem[ba - bas_off];
		return 8'hFF;
	endfunction

	task automatic load_image(input file_idx_t idx, input bit to_os, input int n);
		logic [31:0] rnd;
		load.download = 1'b1;
		load.index = idx;
		@(negedge clk_sys);
		for (int i = 0; i < n; i++) begin
			rnd = $random(seed);
			load.wr = 1'b1;
			load.addr = os_addr_t'(i);
			load.dout = rnd[7:0];
			if (to_os) begin
				os_mem[i] = rnd[7:0];
				os_off = os_addr_t'(16383 - i);
			end else begin
				bas_mem[i] = rnd[7:0];
				bas_off = bas_addr_t'(8191 - i);
			end
			@(negedge clk_sys);
		end
		load.wr = 1'b0;
		@(negedge clk_sys);
		load.download = 1'b0;
	endtask

	task automatic read_check(input rom_addr_t a);
		rom_addr_i = a;
		@(negedge clk_sys);
		check_value("rom_data_o", rom_data_o, expected_rom(a));
	endtask

	task automatic random_reads(input int n);
		logic [31:0] rnd;
		for (int i = 0; i < n; i++) begin
			rnd = $random(seed);
			read_check(rnd[14:0]);
		end
	endtask

	task automatic pulse_check(input bit expect_pulse);
		@(negedge clk_sys);
		check_value("cold_reset_o", cold_reset_o, 0);
		pulse_left = expect_pulse ? RESET_PULSE_CYCLES : 0;
		for (int i = 0; i < RESET_PULSE_CYCLES + 4; i++) begin
			@(negedge clk_sys);
			check_value("cold_reset_o", cold_reset_o, pulse_left != 0);
			if (pulse_left != 0) pulse_left--;
		end
	endtask

	task automatic mouse_step(input bit drift, input bit push_neg);
		logic [31:0] rnd;
		int r;
		axis_t ex, ey;
		joy_btn_t eb;
		r = $unsigned($random(seed)) % 16;
		rnd = $random(seed);
		mouse_i = rnd[24:0];
		mouse_i.strobe = strobe_m ^ rnd[31] ^ rnd[30] ^ 1'b1;
		invert_y_i = rnd[29];
		if (drift) begin
			// Same direction on every packet walks both axes into a limit
			mouse_i.x_sign = push_neg;
			mouse_i.y_sign = push_neg ^ rnd[29];
			r = 15;
		end
		rnd = $random(seed);
		joy_buttons_i = rnd[13:0];
		joy_x = (r == 0) ? axis_t'(rnd[23:16]) : '0;
		joy_y = (r == 1) ? axis_t'(rnd[31:24]) : '0;
		cpu_halt_i = (r == 2);
		@(posedge clk_sys);
		if (joy_x != 0 || joy_y != 0 || cpu_halt_i) begin
			ctrl_m = 1'b0;
			acc_x = 0;
			acc_y = 0;
		end else if (mouse_i.strobe != strobe_m) begin
			ctrl_m = 1'b1;
			acc_x = clamp_int(acc_x + mouse_delta(mouse_i.x_sign, mouse_i.dx), AXIS_MIN, AXIS_MAX);
			acc_y = invert_y_i ? acc_y - mouse_delta(mouse_i.y_sign, mouse_i.dy) :
				acc_y + mouse_delta(mouse_i.y_sign, mouse_i.dy);
			acc_y = clamp_int(acc_y, AXIS_MIN, AXIS_MAX);
		end
		strobe_m = mouse_i.strobe;
		@(negedge clk_sys);
		ex = ctrl_m ? axis_t'(acc_x) : joy_x;
		ey = ctrl_m ? axis_t'(acc_y) : joy_y;
		eb = joy_buttons_i;
		if (ctrl_m) eb[8:7] = mouse_i.btn;
		check_value("axis_x_o", axis_x_o, ex);
		check_value("axis_y_o", axis_y_o, ey);
		check_value("joy_buttons_o", joy_buttons_o, eb);
	endtask

	// Watchdog
	initial begin
		repeat (2 * TEST_CYCLES) @(posedge clk_sys);
		$display("Error: the tests did not finish before the watchdog expired");
		$display("TEST FAILED");
		$fatal(1);
	end

	initial begin
		int n;
		logic [31:0] rnd;
		seed = 32'hac23a046;
		load = '0;
		reset_req = 1'b0;
		basic_en_i = 1'b1;
		rom_addr_i = '0;
		mouse_i = '0;
		invert_y_i = 1'b0;
		joy_x = '0;
		joy_y = '0;
		joy_buttons_i = '0;
		cpu_halt_i = 1'b0;
		os_off = '0;
		bas_off = '0;
		bas_en_m = 1'b1;
		ctrl_m = 1'b0;
		strobe_m = 1'b0;
		acc_x = 0;
		acc_y = 0;
		wait (!areset);
		@(negedge clk_sys);

		// Full images, then the unmapped window at 2000-3FFF
		load_image(IDX_OS_BOOT, 1'b1, 16384);
		load_image(IDX_BAS_BOOT, 1'b0, 8192);
		random_reads(N_READS);
		for (int i = 0; i < 100; i++) begin
			rnd = $random(seed);
			read_check({2'b01, rnd[12:0]});
		end

		// Short OS image sits at the top of the bank
		n = 16 + $unsigned($random(seed)) % 496;
		load_image(IDX_OS_MENU, 1'b1, n);
		for (int i = 0; i < N_READS; i++) begin
			rnd = $random(seed);
			read_check({1'b1, os_addr_t'(16383 - (rnd[15:0] % (n + 32)))});
		end
		random_reads(N_READS);

		// Reset with BASIC disabled clears both offsets
		basic_en_i = 1'b0;
		reset_req = 1'b1;
		repeat (2) @(negedge clk_sys);
		reset_req = 1'b0;
		// BASIC enable is only taken during reset
		basic_en_i = 1'b1;
		bas_en_m = 1'b0;
		os_off = '0;
		bas_off = '0;
		random_reads(N_READS);

		// Cold reset only for a ROM the machine runs from
		load_image(IDX_BAS_MENU, 1'b0, 32);
		pulse_check(1'b0);
		load_image(IDX_OS_BOOT, 1'b1, 64);
		pulse_check(1'b1);
		random_reads(N_READS);

		for (int i = 0; i < N_MOUSE; i++) begin
			mouse_step(1'b0, 1'b0);
		end
		// Runs in one direction reach the upper and then the lower stick limit
		for (int i = 0; i < N_DRIFT; i++) begin
			mouse_step(1'b1, 1'b0);
		end
		for (int i = 0; i < N_DRIFT; i++) begin
			mouse_step(1'b1, 1'b1);
		end

		$display("TEST PASSED");
		$finish;
	end

endmodule

/* files.f */
source/a8_pkg.sv
source/rom_bank.sv
source/rom_loader.sv
source/load_reset_gen.sv
source/mouse_axis.sv
source/a8_host_top.sv
tests/clk_gen.sv
tests/tb_top.sv

/* run.sh */
#!/bin/bash
# Build and run the testbench with Verilator, the log decides the result

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f files.f --top-module tb_top -o tb_top \
	&& ./obj_dir/tb_top > sim.log 2>&1 \
	|| echo "compile or simulation ended with an error"

if [ -f sim.log ]; then
	cat sim.log
fi

grep -q "TEST PASSED" sim.log 2>/dev/null && exit 0 || exit 1
